/* source/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth  = 8;
    localparam int instrWidth = 16;

    // Opcodes, E and F do nothing
    localparam logic [3:0] opAnd = 4'h0;
    localparam logic [3:0] opOr  = 4'h1;
    localparam logic [3:0] opNot = 4'h2;
    localparam logic [3:0] opAdd = 4'h3;
    localparam logic [3:0] opSub = 4'h4;
    localparam logic [3:0] opLsr = 4'h5;
    localparam logic [3:0] opLsl = 4'h6;
    localparam logic [3:0] opInc = 4'h7;
    localparam logic [3:0] opDec = 4'h8;
    localparam logic [3:0] opBra = 4'h9;
    localparam logic [3:0] opBne = 4'hA;
    localparam logic [3:0] opMov = 4'hB;
    localparam logic [3:0] opLd  = 4'hC;
    localparam logic [3:0] opSt  = 4'hD;

    // Codes 6 and 7 decode as PC too
    localparam logic [2:0] regR0 = 3'd0;
    localparam logic [2:0] regR1 = 3'd1;
    localparam logic [2:0] regR2 = 3'd2;
    localparam logic [2:0] regR3 = 3'd3;
    localparam logic [2:0] regAr = 3'd4;
    localparam logic [2:0] regPc = 3'd5;

    localparam logic [2:0] aluPassA = 3'd0;
    localparam logic [2:0] aluAnd   = 3'd1;
    localparam logic [2:0] aluOr    = 3'd2;
    localparam logic [2:0] aluNot   = 3'd3;
    localparam logic [2:0] aluAdd   = 3'd4;
    localparam logic [2:0] aluSub   = 3'd5;
    localparam logic [2:0] aluLsl   = 3'd6;
    localparam logic [2:0] aluLsr   = 3'd7;

    localparam logic [1:0] funcHold = 2'd0;
    localparam logic [1:0] funcLoad = 2'd1;
    localparam logic [1:0] funcDec  = 2'd2;
    localparam logic [1:0] funcInc  = 2'd3;

    localparam logic [1:0] grfFromAlu = 2'd0;
    localparam logic [1:0] grfFromMem = 2'd1;
    localparam logic [1:0] grfFromImm = 2'd2;

    localparam logic arfFromAlu = 1'b0;
    localparam logic arfFromImm = 1'b1;

    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dst;
            logic [2:0] src1;
            logic [2:0] src2;
            logic [2:0] spare;
        } regForm;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] regSel;
            logic       addrMode;  // 1 is direct
            logic       spare;
            logic [7:0] addr;
        } addrForm;
    } instrWord_u;

endpackage

/* source/phaseCounter.sv */
module phaseCounter (
    input  logic       clk,
    input  logic       rstN,
    input  logic       clear,
    output logic [1:0] phase
);

    // T0 and T1 fetch, T2 executes, T3 only for two-step INC and DEC.
    // The control unit raises clear in the last cycle of every instruction,
    // so the counter never wraps on its own in normal operation.

    logic [1:0] nextPhase;

    assign nextPhase = phase + 2'd1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= 2'd0;
        end else if (clear) begin
            phase <= 2'd0;  // Next instruction starts
        end else begin
            phase <= nextPhase;
        end
    end

endmodule

/* source/controlUnit.sv */
module controlUnit (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [1:0]                   phase,
    input  logic                         zero,
    input  logic [cpuPkg::dataWidth-1:0] memReadData,
    output logic                         phaseClear,
    output logic                         memRead,
    output logic                         memWrite,
    output logic [cpuPkg::dataWidth-1:0] immediate,
    output logic [1:0]                   grfFunc,
    output logic [3:0]                   grfMask,
    output logic [1:0]                   grfInSel,
    output logic [1:0]                   grfReadA,
    output logic [1:0]                   grfReadB,
    output logic [1:0]                   arfFunc,
    output logic [1:0]                   arfMask,
    output logic                         arfInSel,
    output logic                         arfReadA,
    output logic                         arfReadB,
    output logic [2:0]                   aluOp,
    output logic                         aluSrcArf,
    output logic                         flagUpdate
);
    import cpuPkg::*;

    localparam logic pcIdx = 1'b0;  // Slot of PC in the address file
    localparam logic arIdx = 1'b1;

    instrWord_u instr;

    logic [3:0] opcode;
    logic [2:0] dst;
    logic [2:0] src1;
    logic [1:0] regSel;
    logic       addrMode;
    logic       isAluOp;
    logic       twoStep;
    logic [1:0] stepFunc;
    logic [1:0] destFunc;
    logic [3:0] dstGrfMask;
    logic [1:0] dstArfMask;

    function automatic logic arfIdx(input logic [2:0] code);
        return (code == regAr) ? arIdx : pcIdx;
    endfunction

    // Codes 6 and 7 are aliases of PC
    function automatic logic [2:0] physReg(input logic [2:0] code);
        return (code > regPc) ? regPc : code;
    endfunction

    function automatic logic [2:0] aluOpFor(input logic [3:0] code);
        case (code)
            opAnd:   return aluAnd;
            opOr:    return aluOr;
            opNot:   return aluNot;
            opAdd:   return aluAdd;
            opSub:   return aluSub;
            opLsl:   return aluLsl;
            opLsr:   return aluLsr;
            default: return aluPassA;  // MOV, INC copy and ST
        endcase
    endfunction

    // Low byte arrives first
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instr <= '0;
        end else if (phase == 2'd0) begin
            instr[dataWidth-1:0] <= memReadData;
        end else if (phase == 2'd1) begin
            instr[instrWidth-1:dataWidth] <= memReadData;
        end
    end

    assign opcode     = instr.regForm.opcode;
    assign dst        = instr.regForm.dst;
    assign src1       = instr.regForm.src1;
    assign regSel     = instr.addrForm.regSel;
    assign addrMode   = instr.addrForm.addrMode;
    assign immediate  = instr.addrForm.addr;

    assign isAluOp    = opcode inside {opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov};
    assign twoStep    = (opcode == opInc || opcode == opDec) && physReg(dst) != physReg(src1);
    assign stepFunc   = (opcode == opInc) ? funcInc : funcDec;
    assign dstGrfMask = 4'b0001 << dst[1:0];
    assign dstArfMask = 2'b01 << arfIdx(dst);

    always_comb begin
        phaseClear = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        grfFunc    = funcHold;
        grfMask    = '0;
        grfInSel   = grfFromAlu;
        grfReadA   = src1[1:0];
        grfReadB   = instr.regForm.src2[1:0];
        arfFunc    = funcHold;
        arfMask    = '0;
        arfInSel   = arfFromAlu;
        arfReadA   = arfIdx(src1);
        arfReadB   = pcIdx;  // PC addresses memory unless LD or ST direct
        aluOp      = aluOpFor(opcode);
        aluSrcArf  = src1[2];
        flagUpdate = 1'b0;
        destFunc   = funcHold;

        case (phase)
            2'd0, 2'd1: begin  // Fetch byte at PC, then step PC
                memRead = 1'b1;
                arfFunc = funcInc;
                arfMask = 2'b01 << pcIdx;
            end
            2'd2: begin
                phaseClear = !twoStep;
                if (isAluOp) begin
                    destFunc   = funcLoad;
                    flagUpdate = 1'b1;
                end else begin
                    case (opcode)
                        opInc, opDec: destFunc = twoStep ? funcLoad : stepFunc;
                        opBra, opBne: begin
                            if (!addrMode && (opcode == opBra || !zero)) begin
                                arfFunc  = funcLoad;
                                arfMask  = 2'b01 << pcIdx;
                                arfInSel = arfFromImm;
                            end
                        end
                        opLd: begin
                            grfFunc = funcLoad;
                            grfMask = 4'b0001 << regSel;
                            if (addrMode) begin
                                grfInSel = grfFromMem;
                                memRead  = 1'b1;
                                arfReadB = arIdx;
                            end else begin
                                grfInSel = grfFromImm;
                            end
                        end
                        opSt: begin
                            if (addrMode) begin  // Register passes through ALU to the bus
                                memWrite  = 1'b1;
                                arfReadB  = arIdx;
                                grfReadA  = regSel;
                                aluSrcArf = 1'b0;
                                aluOp     = aluPassA;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            default: begin  // T3 steps the copied value
                phaseClear = 1'b1;
                if (twoStep) begin
                    destFunc = stepFunc;
                end
            end
        endcase

        if (destFunc != funcHold) begin
            if (dst[2]) begin
                arfFunc = destFunc;
                arfMask = dstArfMask;
            end else begin
                grfFunc = destFunc;
                grfMask = dstGrfMask;
            end
        end
    end

endmodule

/* source/generalRegFile.sv */
module generalRegFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [1:0]                   func,
    input  logic [3:0]                   mask,
    input  logic [1:0]                   inSel,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    input  logic [cpuPkg::dataWidth-1:0] memData,
    input  logic [cpuPkg::dataWidth-1:0] immediate,
    input  logic [1:0]                   readSelA,
    input  logic [1:0]                   readSelB,
    output logic [cpuPkg::dataWidth-1:0] readA,
    output logic [cpuPkg::dataWidth-1:0] readB
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [4];  // R0 to R3
    logic [dataWidth-1:0] inData;

    always_comb begin
        case (inSel)
            grfFromMem: inData = memData;
            grfFromImm: inData = immediate;
            default:    inData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    case (func)
                        funcLoad: regs[i] <= inData;
                        funcDec:  regs[i] <= regs[i] - 1'b1;
                        funcInc:  regs[i] <= regs[i] + 1'b1;
                        default:  regs[i] <= regs[i];
                    endcase
                end
            end
        end
    end

    assign readA = regs[readSelA];  // ALU operand A
    assign readB = regs[readSelB];  // ALU operand B

endmodule

/* source/addressRegFile.sv */
module addressRegFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [1:0]                   func,
    input  logic [1:0]                   mask,
    input  logic                         inSel,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    input  logic [cpuPkg::dataWidth-1:0] immediate,
    input  logic                         readSelA,
    input  logic                         readSelB,
    output logic [cpuPkg::dataWidth-1:0] readA,
    output logic [cpuPkg::dataWidth-1:0] readB
);
    import cpuPkg::*;

    // Slot 0 is PC, slot 1 is AR
    logic [dataWidth-1:0] regs [2];
    logic [dataWidth-1:0] inData;

    assign inData = (inSel == arfFromImm) ? immediate : aluResult;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (mask[i]) begin
                    case (func)
                        funcLoad: regs[i] <= inData;  // Branch target or ALU result
                        funcDec:  regs[i] <= regs[i] - 1'b1;
                        funcInc:  regs[i] <= regs[i] + 1'b1;
                        default:  regs[i] <= regs[i];
                    endcase
                end
            end
        end
    end

    assign readA = regs[readSelA];  // To ALU
    assign readB = regs[readSelB];  // Memory address

endmodule

/* source/alu.sv */
module alu (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [2:0]                   op,
    input  logic                         srcArf,
    input  logic                         flagUpdate,
    input  logic [cpuPkg::dataWidth-1:0] grfA,
    input  logic [cpuPkg::dataWidth-1:0] arfA,
    input  logic [cpuPkg::dataWidth-1:0] operandB,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic                         zero
);
    import cpuPkg::*;

    logic [dataWidth-1:0] operandA;

    // Source 1 may name PC or AR
    assign operandA = srcArf ? arfA : grfA;

    always_comb begin
        case (op)
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluNot:  result = ~operandA;
            aluAdd:  result = operandA + operandB;  // Modulo 256
            aluSub:  result = operandA - operandB;
            aluLsl:  result = {operandA[dataWidth-2:0], 1'b0};
            aluLsr:  result = {1'b0, operandA[dataWidth-1:1]};
            default: result = operandA;  // Pass for MOV and stores
        endcase
    end

    // Z is the only flag, read by BNE
    always_ff @(posedge clk) begin
        if (!rstN) begin
            zero <= 1'b0;
        end else if (flagUpdate) begin
            zero <= (result == '0);
        end
    end

endmodule

/* source/cpuTop.sv */
module cpuTop (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [cpuPkg::dataWidth-1:0] memReadData,
    output logic [cpuPkg::dataWidth-1:0] memAddr,
    output logic [cpuPkg::dataWidth-1:0] memWriteData,
    output logic                         memWrite,
    output logic                         memRead
);
    import cpuPkg::*;

    logic [1:0]           phase;
    logic                 phaseClear;
    logic                 zero;
    logic [dataWidth-1:0] immediate;

    logic [1:0]           grfFunc;
    logic [3:0]           grfMask;
    logic [1:0]           grfInSel;
    logic [1:0]           grfReadA;
    logic [1:0]           grfReadB;
    logic [dataWidth-1:0] grfDataA;
    logic [dataWidth-1:0] grfDataB;

    logic [1:0]           arfFunc;
    logic [1:0]           arfMask;
    logic                 arfInSel;
    logic                 arfReadA;
    logic                 arfReadB;
    logic [dataWidth-1:0] arfDataA;

    logic [2:0]           aluOp;
    logic                 aluSrcArf;
    logic                 flagUpdate;
    logic [dataWidth-1:0] aluResult;

    assign memWriteData = aluResult;  // ST routes the register through the ALU

    phaseCounter phaseCnt (
        .clk(clk), .rstN(rstN), .clear(phaseClear), .phase(phase)
    );

    controlUnit ctrl (
        .clk(clk), .rstN(rstN), .phase(phase), .zero(zero), .memReadData(memReadData),
        .phaseClear(phaseClear), .memRead(memRead), .memWrite(memWrite),
        .immediate(immediate), .grfFunc(grfFunc), .grfMask(grfMask), .grfInSel(grfInSel),
        .grfReadA(grfReadA), .grfReadB(grfReadB), .arfFunc(arfFunc), .arfMask(arfMask),
        .arfInSel(arfInSel), .arfReadA(arfReadA), .arfReadB(arfReadB), .aluOp(aluOp),
        .aluSrcArf(aluSrcArf), .flagUpdate(flagUpdate)
    );

    generalRegFile grf (
        .clk(clk), .rstN(rstN), .func(grfFunc), .mask(grfMask), .inSel(grfInSel),
        .aluResult(aluResult), .memData(memReadData), .immediate(immediate),
        .readSelA(grfReadA), .readSelB(grfReadB), .readA(grfDataA), .readB(grfDataB)
    );

    addressRegFile arf (
        .clk(clk), .rstN(rstN), .func(arfFunc), .mask(arfMask), .inSel(arfInSel),
        .aluResult(aluResult), .immediate(immediate), .readSelA(arfReadA),
        .readSelB(arfReadB), .readA(arfDataA), .readB(memAddr)
    );

    alu aluUnit (
        .clk(clk), .rstN(rstN), .op(aluOp), .srcArf(aluSrcArf), .flagUpdate(flagUpdate),
        .grfA(grfDataA), .arfA(arfDataA), .operandB(grfDataB),
        .result(aluResult), .zero(zero)
    );

endmodule

/* tb/cpuTop_properties.sv */
module cpuTop_properties (
    input logic       clk,
    input logic       rstN,
    input logic       memWrite,
    input logic       memRead,
    input logic       phaseClear,
    input logic [1:0] phase
);

    int failCount = 0;

    busExclusive: assert property (@(posedge clk) disable iff (!rstN) !(memWrite && memRead))
        else begin
            $error("memWrite and memRead high in the same cycle");
            failCount++;
        end

    // First cycle out of reset is a fetch
    noWriteAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !memWrite)
        else begin
            $error("memWrite high in the cycle after reset");
            failCount++;
        end

    // The control unit ends every T3 itself
    phaseWrapsToT0: assert property (@(posedge clk) disable iff (!rstN)
        phase == 2'd3 |-> phaseClear ##1 phase == 2'd0)
        else begin
            $error("phase left T3 without a clear back to T0");
            failCount++;
        end

endmodule

bind cpuTop cpuTop_properties props (
    .clk(clk), .rstN(rstN), .memWrite(memWrite), .memRead(memRead),
    .phaseClear(phaseClear), .phase(phase)
);

/* tb/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [7:0] modelMem [256];
logic [7:0] modelGr [4];
logic [7:0] modelPc;
logic [7:0] modelAr;
logic       modelZ;

// Right-shifting Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
endfunction

function automatic logic [7:0] readCode(input logic [2:0] code);
    if (code == regAr) begin
        return modelAr;
    end
    return code[2] ? modelPc : modelGr[code[1:0]];  // 5 to 7 all name PC
endfunction

function automatic void writeCode(input logic [2:0] code, input logic [7:0] value);
    if (code == regAr) begin
        modelAr = value;
    end else if (code[2]) begin
        modelPc = value;
    end else begin
        modelGr[code[1:0]] = value;
    end
endfunction

// Runs the program image at instruction level and queues every store
function automatic void predictStores();
    logic [15:0] word;
    logic [7:0]  start;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  res;
    logic        direct;
    int          steps;
    modelMem = image;
    modelGr  = '{default: 8'h00};
    modelPc  = 8'h00;
    modelAr  = 8'h00;
    modelZ   = 1'b0;
    for (steps = 0; steps < 1000; steps++) begin
        start   = modelPc;
        word    = {modelMem[start + 8'd1], modelMem[start]};  // Low byte first
        modelPc = start + 8'd2;
        direct  = word[9];
        a       = readCode(word[8:6]);
        b       = modelGr[word[4:3]];
        case (word[15:12])
            opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov: begin
                case (word[15:12])
                    opAnd:   res = a & b;
                    opOr:    res = a | b;
                    opNot:   res = ~a;
                    opAdd:   res = a + b;
                    opSub:   res = a - b;
                    opLsr:   res = a >> 1;
                    opLsl:   res = a << 1;
                    default: res = a;
                endcase
                writeCode(word[11:9], res);
                modelZ = (res == 8'h00);
            end
            opInc: writeCode(word[11:9], a + 8'd1);  // Flags untouched
            opDec: writeCode(word[11:9], a - 8'd1);
            opBra, opBne: begin
                if (!direct && (word[15:12] == opBra || !modelZ)) begin
                    if (word[7:0] == start) begin
                        return;  // Jump to itself ends the program
                    end
                    modelPc = word[7:0];
                end
            end
            opLd: modelGr[word[11:10]] = direct ? modelMem[modelAr] : word[7:0];
            opSt: begin
                if (direct) begin
                    modelMem[modelAr] = modelGr[word[11:10]];
                    expAddr.push_back(modelAr);
                    expData.push_back(modelGr[word[11:10]]);
                end
            end
            default: ;
        endcase
    end
endfunction

`endif

/* tb/cpuTb.sv */
module cpuTb;
    import cpuPkg::*;

    logic                 clk;
    logic                 rstN;
    logic [dataWidth-1:0] memReadData;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWriteData;
    logic                 memWrite;
    logic                 memRead;

    logic [7:0]  mem [256];
    logic [7:0]  image [256];  // Program loaded into mem during reset
    logic [7:0]  expAddr [$];
    logic [7:0]  expData [$];
    logic [31:0] lfsrState;
    logic [7:0]  progPtr;

    `include "cpuModel.svh"

    cpuTop dut (
        .clk(clk), .rstN(rstN), .memReadData(memReadData), .memAddr(memAddr),
        .memWriteData(memWriteData), .memWrite(memWrite), .memRead(memRead)
    );

    assign memReadData = mem[memAddr];

    always @(posedge clk) begin
        if (!rstN) begin
            mem <= image;
        end else if (memWrite) begin
            mem[memAddr] <= memWriteData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportFailure();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [7:0] randByte();
        logic [7:0] value;
        int         i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[6:0], lfsrState[0]};
        end
        return value;
    endfunction

    task automatic emitWord(input logic [15:0] word);
        image[progPtr]        = word[7:0];
        image[progPtr + 8'd1] = word[15:8];
        progPtr               = progPtr + 8'd2;
    endtask

    task automatic emitReg(input logic [3:0] op, input logic [2:0] d, input logic [2:0] s1,
                           input logic [2:0] s2);
        emitWord({op, d, s1, s2, 3'b000});
    endtask

    task automatic emitAddr(input logic [3:0] op, input logic [1:0] sel, input logic direct,
                            input logic [7:0] addr);
        emitWord({op, sel, direct, 1'b0, addr});
    endtask

    // ST direct, then AR moves to the next data slot
    task automatic storeNext(input logic [1:0] sel);
        emitAddr(opSt, sel, 1'b1, 8'h00);
        emitReg(opInc, regAr, regAr, regR0);
    endtask

    task automatic buildProgram();
        logic [3:0] aluOps [8];
        int         k;
        aluOps  = '{opAnd, opOr, opNot, opAdd, opSub, opLsl, opLsr, opMov};
        progPtr = 8'h00;
        emitAddr(opLd, 2'd0, 1'b0, 8'hC0);  // Data area starts at C0
        emitReg(opMov, regAr, regR0, regR0);
        for (k = 0; k < 4; k++) begin
            emitAddr(opLd, k[1:0], 1'b0, randByte());
        end
        for (k = 0; k < 4; k++) begin
            storeNext(k[1:0]);
        end
        emitReg(opDec, regAr, regAr, regR0);  // Back to the R3 slot
        emitAddr(opLd, 2'd1, 1'b1, 8'h00);
        emitReg(opInc, regAr, regAr, regR0);
        storeNext(2'd1);
        emitAddr(opLd, 2'd0, 1'b0, randByte());
        emitAddr(opLd, 2'd1, 1'b0, randByte());
        for (k = 0; k < 8; k++) begin
            emitReg(aluOps[k], regR2, regR0, regR1);
            storeNext(2'd2);
        end
        emitAddr(opLd, 2'd0, 1'b0, 8'hFF);
        emitReg(opInc, regR0, regR0, regR0);  // Wraps to 00
        storeNext(2'd0);
        emitReg(opDec, regR0, regR0, regR0);
        storeNext(2'd0);
        emitReg(opInc, regR1, regR0, regR0);  // Two-step forms
        storeNext(2'd1);
        emitReg(opDec, regR2, regR1, regR0);
        storeNext(2'd2);
        // Each branch target lies past one store pair
        emitReg(opSub, regR2, regR0, regR0);
        emitAddr(opBne, 2'd0, 1'b0, progPtr + 8'd6);
        storeNext(2'd2);
        emitAddr(opLd, 2'd3, 1'b0, 8'h01);
        emitReg(opSub, regR2, regR3, regR2);
        emitAddr(opBne, 2'd0, 1'b0, progPtr + 8'd6);
        storeNext(2'd3);
        emitAddr(opBra, 2'd0, 1'b0, progPtr + 8'd6);
        storeNext(2'd0);
        emitAddr(opBra, 2'd0, 1'b1, randByte());
        emitAddr(opBne, 2'd0, 1'b1, randByte());
        storeNext(2'd2);
        emitAddr(opBra, 2'd0, 1'b0, progPtr);
    endtask

    always @(negedge clk) begin
        if (rstN && memWrite) begin
            assert (expAddr.size() != 0) else begin
                $display("store to %h after the last expected store", memAddr);
                reportFailure();
            end
            assert (memAddr === expAddr[0]) else begin
                $display("[FAIL] memAddr got %h, expected %h", memAddr, expAddr[0]);
                reportFailure();
            end
            assert (memWriteData === expData[0]) else begin
                $display("[FAIL] memWriteData got %h, expected %h", memWriteData, expData[0]);
                reportFailure();
            end
            void'(expAddr.pop_front());
            void'(expData.pop_front());
        end
    end

    initial begin
        int a;
        int waitCycles;
        rstN       = 1'b0;
        lfsrState  = 32'h90ca;
        for (a = 0; a < 256; a++) begin
            image[a] = a[7:0] ^ 8'hA5;
        end
        buildProgram();
        predictStores();
        repeat (3) @(posedge clk);
        #10 rstN = 1'b1;
        @(negedge clk);
        assert (memRead === 1'b1) else begin
            $display("memRead is not high in the first fetch after reset");
            reportFailure();
        end
        assert (memAddr === 8'h00) else begin
            $display("[FAIL] memAddr got %h, expected 00", memAddr);
            reportFailure();
        end
        waitCycles = 0;
        while (expAddr.size() != 0 && waitCycles < 3000) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expAddr.size() != 0) begin
            $display("timed out with %0d stores still missing", expAddr.size());
            reportFailure();
        end
        waitCycles = 0;
        while (waitCycles < 60) begin  // Halt loop must stay quiet
            @(posedge clk);
            waitCycles++;
        end
        if (dut.props.failCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d bus or phase assertion failures", dut.props.failCount);
            reportFailure();
        end
    end

endmodule

/* compile.f */
+incdir+tb
source/cpuPkg.sv
source/phaseCounter.sv
source/controlUnit.sv
source/generalRegFile.sv
source/addressRegFile.sv
source/alu.sv
source/cpuTop.sv
tb/cpuTop_properties.sv
tb/cpuTb.sv

/* Bender.yml */
package:
  name: small_cpu

sources:
  - source/cpuPkg.sv
  - source/phaseCounter.sv
  - source/controlUnit.sv
  - source/generalRegFile.sv
  - source/addressRegFile.sv
  - source/alu.sv
  - source/cpuTop.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cpuTop_properties.sv
      - tb/cpuTb.sv
